// ==== include/cpu16_params.svh ====
`ifndef CPU16_PARAMS_SVH
`define CPU16_PARAMS_SVH

// Register file size
`define NUM_REGS 8

// Branch predictor table, indexed by the low bits of pcinc_id
`define PRED_ENTRIES 8

// Up to three writes in flight per register
`define SB_CNT_W 2

`endif

// ==== design/cpu16_pkg.sv ====
package cpu16_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_adr_t;
   typedef logic [3:0]  alu_op_t;
   typedef logic [1:0]  pred_cnt_t;   // 2-bit saturating branch counter

   // Top field of the instruction word
   typedef enum logic [3:0] {
      OP_ALU  = 4'd0,
      OP_LI   = 4'd1,
      OP_LD   = 4'd2,
      OP_ST   = 4'd3,
      OP_BR   = 4'd4,
      OP_OUT  = 4'd5,
      OP_HALT = 4'd15
   } opcode_e;

   typedef enum logic {
      RUN    = 1'b0,
      HALTED = 1'b1
   } ctrl_state_e;

endpackage

// ==== design/decode_ctrl.sv ====
`timescale 1ns/10ps

module decode_ctrl (
   input  logic                clk,
   input  logic                rst_n,
   input  cpu16_pkg::word_t    inst_id,
   input  logic                hazard,
   input  logic                mem_busy,
   input  logic                resolve_valid,
   input  logic                resolve_miss,
   input  cpu16_pkg::word_t    pcinc_ex,
   output cpu16_pkg::reg_adr_t rs1_adr,
   output cpu16_pkg::reg_adr_t rs2_adr,
   output cpu16_pkg::reg_adr_t regwrite_adr_id,
   output logic                uses_rs1,
   output logic                uses_rs2,
   output logic                issue_write,
   output logic                regwrite_id,
   output cpu16_pkg::alu_op_t  alu_op_id,
   output cpu16_pkg::word_t    extended_d_id,
   output logic                is_branch,
   output logic                main_mem_read_id,
   output logic                main_mem_write_id,
   output logic                out_en_id,
   output logic                is_halt_id,
   output cpu16_pkg::word_t    pcinc_evac,
   output logic                en_pc,
   output logic                en_ifid,
   output logic                flush_ifid,
   output logic                en_idex,
   output logic                flush_idex,
   output logic                en_exmem,
   output logic                en_memwb
);
   import cpu16_pkg::*;

   opcode_e     opcode;
   ctrl_state_e state;
   word_t       imm8_ext;
   word_t       imm6_ext;
   logic        mispredict;
   logic        go;            // ID instruction moves into ID/EX this cycle

   assign opcode   = opcode_e'(inst_id[15:12]);
   assign imm8_ext = {{8{inst_id[7]}}, inst_id[7:0]};
   assign imm6_ext = {{10{inst_id[5]}}, inst_id[5:0]};

   assign rs1_adr         = inst_id[8:6];
   assign rs2_adr         = (opcode == OP_ST) ? inst_id[11:9] : inst_id[5:3];  // Store data in rd field
   assign regwrite_adr_id = inst_id[11:9];

   always_comb begin
      uses_rs1          = 1'b0;
      uses_rs2          = 1'b0;
      regwrite_id       = 1'b0;
      alu_op_id         = '0;
      extended_d_id     = '0;
      is_branch         = 1'b0;
      main_mem_read_id  = 1'b0;
      main_mem_write_id = 1'b0;
      out_en_id         = 1'b0;
      case (opcode)
         OP_ALU: begin
            uses_rs1    = 1'b1;
            uses_rs2    = 1'b1;
            regwrite_id = 1'b1;
            alu_op_id   = {1'b0, inst_id[2:0]};
         end
         OP_LI: begin
            regwrite_id   = 1'b1;
            extended_d_id = imm8_ext;
         end
         OP_LD: begin
            uses_rs1         = 1'b1;
            regwrite_id      = 1'b1;
            main_mem_read_id = 1'b1;
            extended_d_id    = imm6_ext;
         end
         OP_ST: begin
            uses_rs1          = 1'b1;
            uses_rs2          = 1'b1;
            main_mem_write_id = 1'b1;
            extended_d_id     = imm6_ext;
         end
         OP_BR: begin
            is_branch     = 1'b1;
            extended_d_id = imm8_ext;
         end
         OP_OUT: begin
            uses_rs1  = 1'b1;
            out_en_id = 1'b1;
         end
         default: ;   // Halt and unused codes carry no flags
      endcase
   end

   assign mispredict  = resolve_valid & resolve_miss;
   assign go          = (state == RUN) & ~mem_busy & ~mispredict & ~hazard;
   assign issue_write = regwrite_id & go;
   assign is_halt_id  = (opcode == OP_HALT) & go;
   assign pcinc_evac  = pcinc_ex;   // Recovery address for the PC mux

   always_comb begin
      en_pc      = 1'b1;
      en_ifid    = 1'b1;
      flush_ifid = 1'b0;
      en_idex    = 1'b1;
      flush_idex = 1'b0;
      en_exmem   = 1'b1;
      en_memwb   = 1'b1;
      if (mem_busy) begin           // Whole pipe frozen
         en_pc    = 1'b0;
         en_ifid  = 1'b0;
         en_idex  = 1'b0;
         en_exmem = 1'b0;
         en_memwb = 1'b0;
      end else if (state == HALTED) begin
         en_pc      = 1'b0;
         en_ifid    = 1'b0;
         flush_idex = 1'b1;         // Drain the back end with bubbles
      end else if (mispredict) begin
         flush_ifid = 1'b1;
         flush_idex = 1'b1;
      end else if (hazard) begin
         en_pc      = 1'b0;
         en_ifid    = 1'b0;
         flush_idex = 1'b1;
      end else if (is_halt_id) begin
         en_pc   = 1'b0;            // Stop fetch as the halt issues
         en_ifid = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         state <= RUN;
      else if (is_halt_id)
         state <= HALTED;           // Sticky until reset
   end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/10ps
`include "cpu16_params.svh"

module reg_file (
   input  logic                clk,
   input  logic                rst_n,
   input  cpu16_pkg::reg_adr_t rs1_adr,
   input  cpu16_pkg::reg_adr_t rs2_adr,
   input  logic                regwrite,
   input  cpu16_pkg::reg_adr_t regwrite_adr,
   input  cpu16_pkg::word_t    regwrite_dat,
   output cpu16_pkg::word_t    rd1_id,
   output cpu16_pkg::word_t    rd2_id
);
   import cpu16_pkg::*;

   word_t regs [`NUM_REGS];

   // Same-cycle writeback wins over the stored value
   function automatic word_t read_port(reg_adr_t adr);
      if (regwrite && (regwrite_adr == adr))
         return regwrite_dat;
      return regs[adr];
   endfunction

   always_comb begin
      rd1_id = read_port(rs1_adr);
      rd2_id = read_port(rs2_adr);
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `NUM_REGS; i++)
            regs[i] <= '0;
      end else if (regwrite) begin
         regs[regwrite_adr] <= regwrite_dat;
      end
   end

endmodule

// ==== design/reg_scoreboard.sv ====
`timescale 1ns/10ps
`include "cpu16_params.svh"

module reg_scoreboard (
   input  logic                clk,
   input  logic                rst_n,
   input  cpu16_pkg::reg_adr_t rs1_adr,
   input  cpu16_pkg::reg_adr_t rs2_adr,
   input  logic                uses_rs1,
   input  logic                uses_rs2,
   input  logic                issue_write,
   input  cpu16_pkg::reg_adr_t regwrite_adr_id,
   input  logic                regwrite,
   input  cpu16_pkg::reg_adr_t regwrite_adr,
   input  logic                mem_busy,
   output logic                hazard
);
   import cpu16_pkg::*;

   logic [`SB_CNT_W-1:0] pend_cnt [`NUM_REGS];   // Writes in flight per register
   logic [`NUM_REGS-1:0] inc;
   logic [`NUM_REGS-1:0] dec;
   logic                 issue_ok;

   assign issue_ok = issue_write & ~mem_busy;   // Frozen pipe holds the issue back

   always_comb begin
      for (int i = 0; i < `NUM_REGS; i++) begin
         inc[i] = issue_ok && (regwrite_adr_id == reg_adr_t'(i));
         // Writebacks nothing is waiting on are ignored
         dec[i] = regwrite && (regwrite_adr == reg_adr_t'(i)) && (pend_cnt[i] != '0);
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `NUM_REGS; i++)
            pend_cnt[i] <= '0;
      end else begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            if (inc[i] && !dec[i])
               pend_cnt[i] <= pend_cnt[i] + 1'b1;
            else if (dec[i] && !inc[i])
               pend_cnt[i] <= pend_cnt[i] - 1'b1;
         end
      end
   end

   assign hazard = (uses_rs1 && (pend_cnt[rs1_adr] != '0)) ||
                   (uses_rs2 && (pend_cnt[rs2_adr] != '0));

endmodule

// ==== design/branch_predictor.sv ====
`timescale 1ns/10ps
`include "cpu16_params.svh"

module branch_predictor (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             is_branch,
   input  cpu16_pkg::word_t                 pcinc_id,
   input  cpu16_pkg::word_t                 extended_d_id,
   input  logic                             resolve_valid,
   input  logic [$clog2(`PRED_ENTRIES)-1:0] resolve_idx,
   input  logic                             resolve_taken,
   output logic                             jump_pred,
   output cpu16_pkg::word_t                 jump_pred_adr
);
   import cpu16_pkg::*;

   localparam int IDX_W = $clog2(`PRED_ENTRIES);

   pred_cnt_t        ctr [`PRED_ENTRIES];
   logic [IDX_W-1:0] pred_idx;
   pred_cnt_t        res_ctr;

   assign pred_idx      = pcinc_id[IDX_W-1:0];
   assign jump_pred     = is_branch & ctr[pred_idx][1];   // Upper bit set for 2 and 3
   assign jump_pred_adr = pcinc_id + extended_d_id;

   assign res_ctr = ctr[resolve_idx];

   // Train toward the resolved direction, saturating at both ends
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `PRED_ENTRIES; i++)
            ctr[i] <= 2'b01;           // Weakly not-taken
      end else if (resolve_valid) begin
         if (resolve_taken && (res_ctr != 2'b11))
            ctr[resolve_idx] <= res_ctr + 1'b1;
         else if (!resolve_taken && (res_ctr != 2'b00))
            ctr[resolve_idx] <= res_ctr - 1'b1;
      end
   end

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/10ps
`include "cpu16_params.svh"

module decode_stage (
   input  logic                             clk,
   input  logic                             rst_n,
   input  cpu16_pkg::word_t                 inst_id,
   input  cpu16_pkg::word_t                 pcinc_id,
   input  logic                             regwrite,
   input  cpu16_pkg::reg_adr_t              regwrite_adr,
   input  cpu16_pkg::word_t                 regwrite_dat,
   input  logic                             mem_busy,
   input  logic                             resolve_valid,
   input  logic [$clog2(`PRED_ENTRIES)-1:0] resolve_idx,
   input  logic                             resolve_taken,
   input  logic                             resolve_miss,
   input  cpu16_pkg::word_t                 pcinc_ex,
   output cpu16_pkg::word_t                 rd1_id,
   output cpu16_pkg::word_t                 rd2_id,
   output cpu16_pkg::reg_adr_t              regwrite_adr_id,
   output logic                             regwrite_id,
   output cpu16_pkg::alu_op_t               alu_op_id,
   output cpu16_pkg::word_t                 extended_d_id,
   output logic                             is_branch,
   output logic                             main_mem_read_id,
   output logic                             main_mem_write_id,
   output cpu16_pkg::word_t                 out_dat_id,
   output logic                             out_en_id,
   output logic                             is_halt_id,
   output logic                             jump_pred,
   output cpu16_pkg::word_t                 jump_pred_adr,
   output cpu16_pkg::word_t                 pcinc_evac,
   output logic                             en_pc,
   output logic                             en_ifid,
   output logic                             flush_ifid,
   output logic                             en_idex,
   output logic                             flush_idex,
   output logic                             en_exmem,
   output logic                             en_memwb
);
   import cpu16_pkg::*;

   reg_adr_t rs1_adr;
   reg_adr_t rs2_adr;
   logic     uses_rs1;
   logic     uses_rs2;
   logic     issue_write;
   logic     hazard;        // Scoreboard RAW flag into the controller

   decode_ctrl      core_ctrl  ( .* );
   reg_file         regs       ( .* );
   reg_scoreboard   scoreboard ( .* );
   branch_predictor bpred      ( .* );

   assign out_dat_id = rd1_id;   // OUT sends rs1 to the port

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
   output logic clk,
   output logic rst_n,
   input  logic rst_req   // Extra reset pulse from the test sequence
);
   logic por_n;

   initial begin
      clk   = 1'b0;
      por_n = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      por_n = 1'b1;
   end

   always #5 clk = ~clk;   // 10 ns period

   assign rst_n = por_n & ~rst_req;

endmodule

// ==== test/decode_sva.sv ====
`timescale 1ns/10ps

module decode_sva (
   input logic clk,
   input logic rst_n,
   input logic mem_busy,
   input logic hazard,
   input logic resolve_valid,
   input logic resolve_miss,
   input logic en_pc,
   input logic flush_ifid,
   input logic flush_idex,
   input logic is_halt_id
);
   logic mispredict;
   logic halt_seen;   // A halt has issued since the last reset

   assign mispredict = resolve_valid & resolve_miss;

   always_ff @(posedge clk) begin
      if (!rst_n)
         halt_seen <= 1'b0;
      else if (is_halt_id)
         halt_seen <= 1'b1;
   end

   // A redirect must let the PC load the recovery address
   flush_needs_pc: assert property (@(posedge clk) disable iff (!rst_n)
      flush_ifid |-> (en_pc || mem_busy))
      else $error("flush_ifid raised while en_pc is low");

   halt_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
      halt_seen |-> !en_pc)
      else $error("en_pc high after a halt issued");

   hazard_bubble: assert property (@(posedge clk) disable iff (!rst_n)
      (hazard && !mispredict && !mem_busy) |-> flush_idex)
      else $error("hazard without a bubble into execute");

endmodule

// ==== test/decode_tb.sv ====
`timescale 1ns/10ps

module decode_tb;
   import cpu16_pkg::*;

   localparam int         NUM_TESTS   = 6;
   localparam word_t      NOP         = 16'h6000;   // Unused opcode
   // Order: en_pc en_ifid flush_ifid en_idex flush_idex en_exmem en_memwb
   localparam logic [6:0] PIPE_RUN    = 7'b1101011;
   localparam logic [6:0] PIPE_HAZ    = 7'b0001111;
   localparam logic [6:0] PIPE_FROZEN = 7'b0000000;
   localparam logic [6:0] PIPE_MISS   = 7'b1111111;

   logic       clk, rst_n, rst_req;
   word_t      inst_id, pcinc_id, regwrite_dat, pcinc_ex;
   logic       regwrite, mem_busy, resolve_valid, resolve_taken, resolve_miss;
   reg_adr_t   regwrite_adr, regwrite_adr_id;
   logic [2:0] resolve_idx;
   word_t      rd1_id, rd2_id, extended_d_id, out_dat_id, jump_pred_adr, pcinc_evac;
   alu_op_t    alu_op_id;
   logic       regwrite_id, is_branch, main_mem_read_id, main_mem_write_id;
   logic       out_en_id, is_halt_id, jump_pred;
   logic       en_pc, en_ifid, flush_ifid, en_idex, flush_idex, en_exmem, en_memwb;

   integer seed   = 32'h42f0;
   int     errors = 0;
   int     failed = 0;
   word_t  model [8];   // Expected register contents

   tb_clock clk_gen (.clk, .rst_n, .rst_req);

   decode_stage dut0 (.*);

   bind decode_ctrl decode_sva sva0 (.clk, .rst_n, .mem_busy, .hazard, .resolve_valid,
      .resolve_miss, .en_pc, .flush_ifid, .flush_idex, .is_halt_id);

   function automatic word_t rnd16();
      return 16'($random(seed));
   endfunction

   task automatic check_word(string sig, word_t got, word_t exp);
      assert (got === exp) else begin
         $display("Error: %s = %h, expected %h", sig, got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(string sig, logic got, logic exp);
      assert (got === exp) else begin
         $display("Error: %s = %h, expected %h", sig, got, exp);
         errors++;
      end
   endtask

   task automatic check_pipe(logic [6:0] exp);
      check_word("{en_pc,en_ifid,flush_ifid,en_idex,flush_idex,en_exmem,en_memwb}",
                 {9'd0, en_pc, en_ifid, flush_ifid, en_idex, flush_idex, en_exmem, en_memwb},
                 {9'd0, exp});
   endtask

   task automatic write_back(reg_adr_t adr, word_t dat);
      regwrite     = 1'b1;
      regwrite_adr = adr;
      regwrite_dat = dat;
      model[adr]   = dat;
   endtask

   task automatic report(string name, int errs_before);
      if (errors == errs_before) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: failed with %0d errors", name, errors - errs_before);
         failed++;
      end
   endtask

   task automatic test_field_decode();
      int         e0;
      word_t      w;
      word_t      exp_ext;
      logic [3:0] op;
      e0       = errors;
      mem_busy = 1'b1;   // Nothing issues, so the scoreboard stays empty
      for (int i = 0; i < 24; i++) begin
         @(negedge clk);
         w        = rnd16();
         w[15:12] = 4'(i % 4);
         op       = w[15:12];
         inst_id  = w;
         if (op == 4'd1)
            exp_ext = {{8{w[7]}}, w[7:0]};
         else if (op == 4'd0)
            exp_ext = '0;
         else
            exp_ext = {{10{w[5]}}, w[5:0]};
         #2;
         check_word("regwrite_adr_id", 16'(regwrite_adr_id), 16'(w[11:9]));
         check_word("extended_d_id", extended_d_id, exp_ext);
         check_word("alu_op_id", 16'(alu_op_id), (op == 4'd0) ? {13'd0, w[2:0]} : 16'd0);
         check_bit("regwrite_id", regwrite_id, op != 4'd3);
         check_bit("main_mem_read_id", main_mem_read_id, op == 4'd2);
         check_bit("main_mem_write_id", main_mem_write_id, op == 4'd3);
         check_bit("is_branch", is_branch, 1'b0);
      end
      @(negedge clk);
      mem_busy = 1'b0;
      inst_id  = NOP;
      report("field decode", e0);
   endtask

   task automatic test_reg_file();
      int    e0;
      word_t w;
      e0       = errors;
      mem_busy = 1'b1;
      for (int i = 0; i < 8; i++) begin
         @(negedge clk);
         write_back(3'(i), rnd16());
      end
      @(negedge clk);
      regwrite = 1'b0;
      for (int i = 0; i < 8; i++) begin
         inst_id = {4'd0, 3'd0, 3'(i), 3'(7 - i), 3'd0};
         #2;
         check_word("rd1_id", rd1_id, model[i]);
         check_word("rd2_id", rd2_id, model[7 - i]);
         @(negedge clk);
      end
      w = rnd16();
      write_back(3'd5, w);
      inst_id = {4'd0, 3'd0, 3'd5, 3'd5, 3'd0};
      #2;
      check_word("rd1_id", rd1_id, w);   // Same-cycle bypass
      @(negedge clk);
      regwrite = 1'b0;
      mem_busy = 1'b0;
      inst_id  = NOP;
      report("register file", e0);
   endtask

   task automatic test_hazard_stall();
      int e0;
      e0 = errors;
      @(negedge clk);
      inst_id = {4'd1, 3'd3, 9'h0ab};   // LI r3
      #2;
      check_pipe(PIPE_RUN);
      @(negedge clk);
      inst_id = {4'd0, 3'd1, 3'd3, 3'd2, 3'd0};   // r1 = r3 op r2
      for (int i = 0; i < 3; i++) begin
         #2;
         check_pipe(PIPE_HAZ);
         @(negedge clk);
      end
      mem_busy = 1'b1;
      #2;
      check_pipe(PIPE_FROZEN);
      @(negedge clk);
      mem_busy = 1'b0;
      write_back(3'd3, rnd16());
      #2;
      check_pipe(PIPE_HAZ);   // Count only drops at the next edge
      @(negedge clk);
      regwrite = 1'b0;
      #2;
      check_pipe(PIPE_RUN);
      @(negedge clk);
      inst_id = NOP;
      write_back(3'd1, rnd16());   // Retire the ALU write
      @(negedge clk);
      regwrite = 1'b0;
      report("hazard stall", e0);
   endtask

   task automatic test_prediction();
      int    e0;
      word_t w;
      e0 = errors;
      w  = rnd16();
      @(negedge clk);
      pcinc_id = 16'h0125;   // Index 5, never trained
      inst_id  = {4'd4, 4'd0, w[7:0]};
      #2;
      check_bit("is_branch", is_branch, 1'b1);
      check_bit("jump_pred", jump_pred, 1'b0);
      check_word("jump_pred_adr", jump_pred_adr, pcinc_id + {{8{w[7]}}, w[7:0]});
      resolve_valid = 1'b1;
      resolve_idx   = 3'd5;
      resolve_taken = 1'b1;
      repeat (2) @(negedge clk);
      resolve_valid = 1'b0;
      #2;
      check_bit("jump_pred", jump_pred, 1'b1);
      check_word("jump_pred_adr", jump_pred_adr, pcinc_id + {{8{w[7]}}, w[7:0]});
      @(negedge clk);
      resolve_taken = 1'b0;
      inst_id       = NOP;
      report("prediction", e0);
   endtask

   task automatic test_mispredict();
      int    e0;
      word_t w;
      e0 = errors;
      @(negedge clk);
      inst_id = {4'd1, 3'd4, 9'h012};   // LI r4
      @(negedge clk);
      inst_id       = {4'd0, 3'd2, 3'd4, 3'd4, 3'd0};
      w             = rnd16();
      pcinc_ex      = w;
      resolve_valid = 1'b1;
      resolve_miss  = 1'b1;
      resolve_idx   = 3'd2;
      #2;
      check_bit("hazard", dut0.hazard, 1'b1);
      check_pipe(PIPE_MISS);
      check_word("pcinc_evac", pcinc_evac, w);
      @(negedge clk);
      resolve_valid = 1'b0;
      resolve_miss  = 1'b0;
      inst_id       = NOP;
      write_back(3'd4, rnd16());
      @(negedge clk);
      regwrite = 1'b0;
      report("mispredict", e0);
   endtask

   task automatic test_halt_output();
      int e0;
      e0 = errors;
      @(negedge clk);
      inst_id = {4'd5, 3'd0, 3'd6, 6'd0};   // OUT r6
      #2;
      check_bit("out_en_id", out_en_id, 1'b1);
      check_word("out_dat_id", out_dat_id, model[6]);
      @(negedge clk);
      inst_id = 16'hf000;
      #2;
      check_bit("is_halt_id", is_halt_id, 1'b1);
      @(negedge clk);
      inst_id = NOP;
      for (int i = 0; i < 4; i++) begin
         #2;
         check_bit("en_pc", en_pc, 1'b0);
         @(negedge clk);
      end
      rst_req = 1'b1;
      @(negedge clk);
      rst_req = 1'b0;
      #2;
      check_bit("en_pc", en_pc, 1'b1);
      report("halt and output", e0);
   endtask

   initial begin
      rst_req       = 1'b0;
      inst_id       = NOP;
      pcinc_id      = '0;
      regwrite      = 1'b0;
      regwrite_adr  = '0;
      regwrite_dat  = '0;
      mem_busy      = 1'b0;
      resolve_valid = 1'b0;
      resolve_idx   = '0;
      resolve_taken = 1'b0;
      resolve_miss  = 1'b0;
      pcinc_ex      = '0;
      for (int i = 0; i < 8; i++)
         model[i] = '0;
      wait (rst_n === 1'b1);
      test_field_decode();
      test_reg_file();
      test_hazard_stall();
      test_prediction();
      test_mispredict();
      test_halt_output();
      $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, failed, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

   // Each test gets 200 cycles
   initial begin
      #(NUM_TESTS * 200 * 10);
      $display("Watchdog expired before the tests finished");
      $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+include
design/cpu16_pkg.sv
design/decode_ctrl.sv
design/reg_file.sv
design/reg_scoreboard.sv
design/branch_predictor.sv
design/decode_stage.sv
test/tb_clock.sv
test/decode_sva.sv
test/decode_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module decode_tb -Mdir obj_dir
./obj_dir/Vdecode_tb | tee sim.log

if grep -q ">>> FAIL" sim.log || ! grep -q ">>> PASS" sim.log; then
   exit 1
fi
